/* src/fperm_settings.svh */
// ---------------------------------------------------------------------
// Permute and estimate unit settings.
// Word width, exponent biases, seed table size and pipeline depth
// shared by the RTL and the testbench.
// ---------------------------------------------------------------------

`ifndef FPERM_SETTINGS_SVH
`define FPERM_SETTINGS_SVH

// Register word, tag plus payload.
`define FP_WORD_W 68

// Biases include the extended exponent bit.
`define FP_BIAS_D 2047
`define FP_BIAS_S 255

// Seed table geometry.
`define FP_TBL_DEPTH 8
`define FP_TBL_IDX_W 3

`define FPERM_LAT 2  // Strobe to result, in cycles.

`endif

/* src/fp_word_pkg.sv */
// ---------------------------------------------------------------------
// Register word layout.
// A word is tagged with its precision and holds either one double or
// a pair of single lanes; the union gives both views of the same bits.
// ---------------------------------------------------------------------

package fp_word_pkg;

  typedef enum logic [1:0] {
    tag_sgl = 2'b00,  // Pair of singles.
    tag_dbl = 2'b01   // One double.
  } fp_tag_e;

  // Double view, 2 + 1 + 1 + 11 + 53 bits.
  typedef struct packed {
    fp_tag_e     tag;
    logic        exp_x;  // Extended exponent bit.
    logic        sign;
    logic [10:0] exp;
    logic [52:0] mant;
  } fp_dbl_t;

  // One single lane, 33 bits.
  typedef struct packed {
    logic        exp_x;
    logic        sign;
    logic [7:0]  exp;
    logic [22:0] mant;
  } fp_sgl_lane_t;

  typedef struct packed {
    fp_tag_e      tag;
    fp_sgl_lane_t hi;
    fp_sgl_lane_t lo;
  } fp_sgl_pair_t;

  // The tag decides which member is meaningful.
  typedef union packed {
    fp_dbl_t      dbl;
    fp_sgl_pair_t sgl;
  } fp_word_u;

endpackage

/* src/fp_op_pkg.sv */
// ---------------------------------------------------------------------
// Permute unit operation codes.
// Operation code and operand select for the permute and estimate unit.
// ---------------------------------------------------------------------

package fp_op_pkg;

  typedef enum logic [2:0] {
    op_move       = 3'd0,  // Copy a or b, optional swap and dup.
    op_recip_seed = 3'd1,
    op_rsqrt_seed = 3'd2,
    op_exp_norm   = 3'd3,  // Leading-one normalize of the exponent.
    op_tbl_read   = 3'd4,
    op_tbl_write  = 3'd5   // No result strobe.
  } perm_op_e;

  // Operand select for moves.
  typedef enum logic {
    src_a = 1'b0,
    src_b = 1'b1
  } perm_src_e;

endpackage

/* src/fp_lead_one.sv */
// ---------------------------------------------------------------------
// Leading-one finder.
// Finds the highest set bit of an exponent field and shifts the field
// left so that bit lands on top.
// ---------------------------------------------------------------------

module fp_lead_one #(
  parameter int W = 12
) (
  input  logic [W-1:0]         field,
  output logic [$clog2(W)-1:0] pos,
  output logic                 found,
  output logic [W-1:0]         norm
);

  localparam int PW = $clog2(W);

  logic [PW:0] shamt;  // One extra bit, W-1 may need it.

  // Scan upward so the last hit is the highest one.
  always_comb begin
    pos = '0;
    for (int i = 0; i < W; i++) begin
      if (field[i]) begin
        pos = PW'(i);
      end
    end
  end

  assign found = |field;

  // Distance from the leading one to the top bit.
  assign shamt = (PW + 1)'(W - 1) - {1'b0, pos};

  // A zero field shifts to zero as well.
  assign norm = field << shamt;

endmodule

/* src/fp_exp_seed.sv */
// ---------------------------------------------------------------------
// Exponent seed datapath.
// Reciprocal and reciprocal square root exponent seeds, and exponent
// normalize, for the double lane and both single lanes of operand b.
// ---------------------------------------------------------------------

`include "fperm_settings.svh"

module fp_exp_seed (
  input  fp_word_pkg::fp_word_u b,
  input  fp_op_pkg::perm_op_e   op,
  output fp_word_pkg::fp_word_u seed_word
);
  import fp_word_pkg::*;
  import fp_op_pkg::*;

  logic [11:0] e_d;    // Double extended exponent.
  logic [3:0]  pos_d;
  logic        found_d;
  logic [11:0] norm_d;
  logic [11:0] rcp_d;
  logic [11:0] rsq_d;
  logic [11:0] nrm_d;
  logic [3:0]  pos_hi;
  logic [3:0]  pos_lo;
  logic        found_hi;
  logic        found_lo;
  logic [8:0]  norm_hi;
  logic [8:0]  norm_lo;

  // Seed one single lane; the sign survives only for the two seeds.
  function automatic fp_sgl_lane_t sgl_seed(input fp_sgl_lane_t lane, input logic [3:0] pos,
                                            input logic found, input logic [8:0] norm,
                                            input perm_op_e sel);
    logic [8:0]   e;
    logic [8:0]   r;
    fp_sgl_lane_t o;
    e = {lane.exp_x, lane.exp};
    o = '0;
    r = '0;
    case (sel)
      op_recip_seed: r = 9'(`FP_BIAS_S) - e;
      op_rsqrt_seed: r = 9'(`FP_BIAS_S) - (e >> 1);
      op_exp_norm:   r = found ? 9'(`FP_BIAS_S) + 9'(pos) : 9'd0;
      default:       r = '0;
    endcase
    {o.exp_x, o.exp} = r;
    if (sel == op_exp_norm) begin
      o.mant[22:14] = norm;  // Left-aligned field.
    end else begin
      o.sign = lane.sign;
    end
    return o;
  endfunction

  assign e_d = {b.dbl.exp_x, b.dbl.exp};

  fp_lead_one #(.W(12)) lead_d_i (.field(e_d), .pos(pos_d), .found(found_d), .norm(norm_d));
  fp_lead_one #(.W(9)) lead_hi_i (.field({b.sgl.hi.exp_x, b.sgl.hi.exp}), .pos(pos_hi),
                                  .found(found_hi), .norm(norm_hi));
  fp_lead_one #(.W(9)) lead_lo_i (.field({b.sgl.lo.exp_x, b.sgl.lo.exp}), .pos(pos_lo),
                                  .found(found_lo), .norm(norm_lo));

  assign rcp_d = 12'(`FP_BIAS_D) - e_d;
  assign rsq_d = 12'(`FP_BIAS_D) - (e_d >> 1);
  assign nrm_d = found_d ? 12'(`FP_BIAS_D) + 12'(pos_d) : 12'd0;

  always_comb begin
    seed_word = '0;
    if (b.dbl.tag == tag_dbl) begin
      seed_word.dbl.tag = b.dbl.tag;
      case (op)
        op_recip_seed: {seed_word.dbl.exp_x, seed_word.dbl.exp} = rcp_d;
        op_rsqrt_seed: {seed_word.dbl.exp_x, seed_word.dbl.exp} = rsq_d;
        op_exp_norm:   {seed_word.dbl.exp_x, seed_word.dbl.exp} = nrm_d;
        default:       seed_word.dbl.exp = '0;
      endcase
      if (op == op_exp_norm) begin
        seed_word.dbl.mant[52:41] = norm_d;
      end else begin
        seed_word.dbl.sign = b.dbl.sign;
      end
    end else begin
      seed_word.sgl.tag = b.sgl.tag;  // Each lane on its own.
      seed_word.sgl.hi  = sgl_seed(b.sgl.hi, pos_hi, found_hi, norm_hi, op);
      seed_word.sgl.lo  = sgl_seed(b.sgl.lo, pos_lo, found_lo, norm_lo, op);
    end
  end

endmodule

/* src/fp_seed_table.sv */
// ---------------------------------------------------------------------
// Seed table.
// Eight register words with a synchronous write port and a one-cycle
// registered read port; cleared on reset.
// ---------------------------------------------------------------------

`include "fperm_settings.svh"

module fp_seed_table (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     we,
  input  logic                     re,
  input  logic [`FP_TBL_IDX_W-1:0] addr,
  input  fp_word_pkg::fp_word_u    wdata,
  output fp_word_pkg::fp_word_u    rdata
);

  logic [`FP_WORD_W-1:0] mem [`FP_TBL_DEPTH];

  // ------------------------------------------------------------------
  // Write port
  // ------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `FP_TBL_DEPTH; i++) begin
        mem[i] <= '0;  // Unwritten entries read back as zero.
      end
    end else begin
      if (we) begin
        mem[addr] <= wdata;
      end
    end
  end

  // ------------------------------------------------------------------
  // Read port
  // ------------------------------------------------------------------

  // Data is held between reads.
  always_ff @(posedge clk) begin
    if (re) begin
      rdata <= mem[addr];
    end
  end

endmodule

/* src/fperm.sv */
// ---------------------------------------------------------------------
// Permute core.
// Operand move with lane swap and low-lane duplicate, result select,
// seed table control and the two-stage result pipeline.
// ---------------------------------------------------------------------

`include "fperm_settings.svh"

module fperm (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     issue,
  input  fp_op_pkg::perm_op_e      op,
  input  fp_op_pkg::perm_src_e     src,
  input  logic                     swap_lanes,
  input  logic                     dup_low,
  input  logic [`FP_TBL_IDX_W-1:0] tbl_idx,
  input  fp_word_pkg::fp_word_u    a,
  input  fp_word_pkg::fp_word_u    b,
  input  fp_word_pkg::fp_word_u    seed_word,
  input  fp_word_pkg::fp_word_u    tbl_data,
  output logic                     tbl_we,
  output logic                     tbl_re,
  output logic [`FP_TBL_IDX_W-1:0] tbl_addr,
  output fp_word_pkg::fp_word_u    tbl_wdata,
  output fp_word_pkg::fp_word_u    res,
  output logic                     res_valid
);
  import fp_word_pkg::*;
  import fp_op_pkg::*;

  fp_word_u pick;      // Selected operand.
  fp_word_u moved;
  fp_word_u sel_word;  // Result before stage 1.
  fp_word_u s1_word;
  perm_op_e s1_op;
  logic     s1_vld;

  // ------------------------------------------------------------------
  // Move path
  // ------------------------------------------------------------------

  assign pick = (src == src_a) ? a : b;

  always_comb begin
    moved = pick;
    if (swap_lanes) begin
      moved.sgl.hi = pick.sgl.lo;
      moved.sgl.lo = pick.sgl.hi;
    end
    if (dup_low) begin
      moved.sgl.hi = moved.sgl.lo;  // Low lane after the swap.
    end
  end

  always_comb begin
    case (op)
      op_move:       sel_word = moved;
      op_recip_seed,
      op_rsqrt_seed,
      op_exp_norm:   sel_word = seed_word;
      default:       sel_word = '0;  // Reads take the table in stage 2.
    endcase
  end

  // Table port runs in the issue cycle.
  assign tbl_we    = issue && (op == op_tbl_write);
  assign tbl_re    = issue && (op == op_tbl_read);
  assign tbl_addr  = tbl_idx;
  assign tbl_wdata = a;

  // ------------------------------------------------------------------
  // Pipeline
  // ------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_vld    <= 1'b0;
      res_valid <= 1'b0;
    end else begin
      s1_vld    <= issue && (op != op_tbl_write);  // Writes stay silent.
      res_valid <= s1_vld;
    end
  end

  always_ff @(posedge clk) begin
    s1_word <= sel_word;
    s1_op   <= op;
    res     <= (s1_op == op_tbl_read) ? tbl_data : s1_word;
  end

endmodule

/* src/fperm_top.sv */
// ---------------------------------------------------------------------
// Permute and estimate unit, top level.
// Joins the permute core, the exponent seed datapath and the seed table.
// ---------------------------------------------------------------------

`include "fperm_settings.svh"

module fperm_top (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     issue,
  input  fp_op_pkg::perm_op_e      op,
  input  fp_op_pkg::perm_src_e     src,
  input  logic                     swap_lanes,
  input  logic                     dup_low,
  input  logic [`FP_TBL_IDX_W-1:0] tbl_idx,
  input  fp_word_pkg::fp_word_u    a,
  input  fp_word_pkg::fp_word_u    b,
  output fp_word_pkg::fp_word_u    res,
  output logic                     res_valid
);
  import fp_word_pkg::*;

  fp_word_u                 seed_word;
  fp_word_u                 tbl_data;   // One cycle after tbl_re.
  fp_word_u                 tbl_wdata;
  logic                     tbl_we;
  logic                     tbl_re;
  logic [`FP_TBL_IDX_W-1:0] tbl_addr;

  fperm perm_i (.clk(clk), .rst(rst), .issue(issue), .op(op), .src(src),
                .swap_lanes(swap_lanes), .dup_low(dup_low), .tbl_idx(tbl_idx), .a(a), .b(b),
                .seed_word(seed_word), .tbl_data(tbl_data), .tbl_we(tbl_we), .tbl_re(tbl_re),
                .tbl_addr(tbl_addr), .tbl_wdata(tbl_wdata), .res(res), .res_valid(res_valid));

  fp_exp_seed seed_i (.b(b), .op(op), .seed_word(seed_word));

  fp_seed_table tbl_i (.clk(clk), .rst(rst), .we(tbl_we), .re(tbl_re), .addr(tbl_addr),
                       .wdata(tbl_wdata), .rdata(tbl_data));

endmodule

/* sim/fperm_props.sv */
// ---------------------------------------------------------------------
// Permute unit properties.
// Reference model of the two-stage pipeline with a shadow seed table,
// and assertions on the result strobe and the result word.
// ---------------------------------------------------------------------

`include "fperm_settings.svh"

module fperm_props (
  input logic                     clk,
  input logic                     rst,
  input logic                     issue,
  input fp_op_pkg::perm_op_e      op,
  input fp_op_pkg::perm_src_e     src,
  input logic                     swap_lanes,
  input logic                     dup_low,
  input logic [`FP_TBL_IDX_W-1:0] tbl_idx,
  input fp_word_pkg::fp_word_u    a,
  input fp_word_pkg::fp_word_u    b,
  input fp_word_pkg::fp_word_u    res,
  input logic                     res_valid
);
  import fp_word_pkg::*;
  import fp_op_pkg::*;

  int       err_cnt = 0;  // Read by the testbench.
  fp_word_u shadow [`FP_TBL_DEPTH];
  fp_word_u exp0;
  fp_word_u exp1;
  logic     vld0;
  logic     vld1;

  // Index of the highest set bit, -1 for a zero field.
  function automatic int top_bit(input logic [11:0] f);
    int p;
    p = -1;
    for (int i = 11; i >= 0; i--) begin
      if (f[i] && p < 0) begin
        p = i;
      end
    end
    return p;
  endfunction

  function automatic fp_sgl_lane_t expect_lane(input perm_op_e o, input fp_sgl_lane_t ln);
    fp_sgl_lane_t r;
    logic [8:0]   e;
    int           p;
    r = '0;
    e = {ln.exp_x, ln.exp};
    p = top_bit({3'b000, e});
    if (o == op_exp_norm) begin
      if (p >= 0) begin
        {r.exp_x, r.exp} = 9'(`FP_BIAS_S + p);
        r.mant[22:14]    = e << (8 - p);
      end
    end else begin
      r.sign = ln.sign;
      if (o == op_recip_seed) begin
        {r.exp_x, r.exp} = 9'(`FP_BIAS_S - int'(e));
      end else begin
        {r.exp_x, r.exp} = 9'(`FP_BIAS_S - int'(e) / 2);
      end
    end
    return r;
  endfunction

  function automatic fp_word_u expect_word(input perm_op_e o, input perm_src_e s,
                                           input logic sw, input logic dp, input fp_word_u wa,
                                           input fp_word_u wb, input fp_word_u tv);
    fp_word_u    w;
    logic [32:0] h;
    logic [32:0] l;
    logic [11:0] e;
    int          p;
    w = '0;
    case (o)
      op_move: begin
        w = (s == src_b) ? wb : wa;
        h = w[65:33];
        l = w[32:0];
        if (sw) begin
          w[65:33] = l;
          w[32:0]  = h;
        end
        if (dp) begin
          w[65:33] = w[32:0];  // Duplicate after the swap.
        end
      end
      op_recip_seed, op_rsqrt_seed, op_exp_norm: begin
        if (wb.dbl.tag == tag_dbl) begin
          e         = {wb.dbl.exp_x, wb.dbl.exp};
          p         = top_bit(e);
          w.dbl.tag = tag_dbl;
          if (o == op_exp_norm) begin
            if (p >= 0) begin
              {w.dbl.exp_x, w.dbl.exp} = 12'(`FP_BIAS_D + p);
              w.dbl.mant[52:41]        = e << (11 - p);
            end
          end else if (o == op_recip_seed) begin
            w.dbl.sign               = wb.dbl.sign;
            {w.dbl.exp_x, w.dbl.exp} = 12'(`FP_BIAS_D - int'(e));
          end else begin
            w.dbl.sign               = wb.dbl.sign;
            {w.dbl.exp_x, w.dbl.exp} = 12'(`FP_BIAS_D - int'(e) / 2);
          end
        end else begin
          w.sgl.tag = wb.sgl.tag;
          w.sgl.hi  = expect_lane(o, wb.sgl.hi);
          w.sgl.lo  = expect_lane(o, wb.sgl.lo);
        end
      end
      op_tbl_read: w = tv;  // Table as seen at issue.
      default:     w = '0;
    endcase
    return w;
  endfunction

  // ------------------------------------------------------------------
  // Reference pipeline
  // ------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      vld0 <= 1'b0;
      vld1 <= 1'b0;
      for (int i = 0; i < `FP_TBL_DEPTH; i++) begin
        shadow[i] <= '0;
      end
    end else begin
      vld0 <= issue && (op != op_tbl_write);
      vld1 <= vld0;
      if (issue && op == op_tbl_write) begin
        shadow[tbl_idx] <= a;
      end
    end
  end

  always_ff @(posedge clk) begin
    exp0 <= expect_word(op, src, swap_lanes, dup_low, a, b, shadow[tbl_idx]);
    exp1 <= exp0;
  end

  // ------------------------------------------------------------------
  // Assertions
  // ------------------------------------------------------------------

  valid_timing: assert property (@(posedge clk) disable iff (rst) res_valid == vld1)
    else begin
      $error("error at %0t: res_valid = %b, expected %b", $time, $sampled(res_valid),
             $sampled(vld1));
      err_cnt++;
    end

  result_value: assert property (@(posedge clk) disable iff (rst) res_valid |-> res == exp1)
    else begin
      $error("error at %0t: res = %h, expected %h", $time, $sampled(res), $sampled(exp1));
      err_cnt++;
    end

  write_silent: assert property (@(posedge clk) disable iff (rst)
                                 (issue && op == op_tbl_write) |-> ##2 !res_valid)
    else begin
      $error("error at %0t: res_valid = 1, expected 0 after a table write", $time);
      err_cnt++;
    end

  quiet_after_reset: assert property (@(posedge clk) $fell(rst) |-> !res_valid)
    else begin
      $error("error at %0t: res_valid = 1, expected 0 right after reset", $time);
      err_cnt++;
    end

endmodule

/* sim/tb_clock.sv */
// ---------------------------------------------------------------------
// Testbench clock.
// Free-running clock for the permute unit testbench.
// ---------------------------------------------------------------------

module tb_clock #(
  parameter int PERIOD = 20
) (
  output logic clk
);

  initial clk = 1'b0;

  always #(PERIOD / 2) clk = ~clk;  // Half period per phase.

endmodule

/* sim/fperm_tb.sv */
// ---------------------------------------------------------------------
// Permute unit testbench.
// Directed and random operations into the permute and estimate unit;
// the bound properties check every result.
// ---------------------------------------------------------------------

`include "fperm_settings.svh"

module fperm_tb;
  import fp_word_pkg::*;
  import fp_op_pkg::*;

  localparam int N_RAND = 300;  // Random operations after the directed part.

  logic                     clk;
  logic                     rst;
  logic                     issue;
  perm_op_e                 op;
  perm_src_e                src;
  logic                     swap_lanes;
  logic                     dup_low;
  logic [`FP_TBL_IDX_W-1:0] tbl_idx;
  fp_word_u                 a;
  fp_word_u                 b;
  fp_word_u                 res;
  logic                     res_valid;

  int       n_issued = 0;
  int       tb_errs = 0;
  int       cyc = 0;
  logic     pend0;
  logic     pend1;
  fp_word_u wz;

  tb_clock #(.PERIOD(20)) clk_i (.clk(clk));

  fperm_top dut_i (.clk(clk), .rst(rst), .issue(issue), .op(op), .src(src),
                   .swap_lanes(swap_lanes), .dup_low(dup_low), .tbl_idx(tbl_idx),
                   .a(a), .b(b), .res(res), .res_valid(res_valid));

  bind fperm_top fperm_props props_i (.*);

  function automatic fp_word_u rand_word(input fp_tag_e t);
    logic [95:0] r;
    fp_word_u    w;
    r     = {$urandom(), $urandom(), $urandom()};
    w     = r[67:0];
    w.dbl.tag = t;
    return w;
  endfunction

  // Starts and ends on a falling edge.
  task automatic issue_op(input perm_op_e o, input perm_src_e s, input logic sw,
                          input logic dp, input logic [2:0] idx, input fp_word_u wa,
                          input fp_word_u wb);
    issue      = 1'b1;
    op         = o;
    src        = s;
    swap_lanes = sw;
    dup_low    = dp;
    tbl_idx    = idx;
    a          = wa;
    b          = wb;
    n_issued++;
    @(negedge clk);
  endtask

  task automatic issue_rand(input perm_op_e o, input perm_src_e s, input fp_tag_e t,
                            input logic sw, input logic dp, input logic [2:0] idx);
    issue_op(o, s, sw, dp, idx, rand_word(t), rand_word(t));
  endtask

  task automatic idle_cycles(input int n);
    issue = 1'b0;
    repeat (n) @(negedge clk);
  endtask

  // ------------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------------

  initial begin
    void'($urandom(24));
    rst        = 1'b1;
    issue      = 1'b0;
    op         = op_move;
    src        = src_a;
    swap_lanes = 1'b0;
    dup_low    = 1'b0;
    tbl_idx    = '0;
    a          = '0;
    b          = '0;
    repeat (8) @(negedge clk);
    rst = 1'b0;
    issue_op(op_tbl_read, src_a, 1'b0, 1'b0, 3'd3, '0, '0);  // Never written.
    issue_rand(op_move, src_a, tag_sgl, 1'b0, 1'b0, 3'd0);
    issue_rand(op_move, src_b, tag_sgl, 1'b0, 1'b0, 3'd0);
    issue_rand(op_move, src_a, tag_sgl, 1'b1, 1'b0, 3'd0);
    issue_rand(op_move, src_b, tag_sgl, 1'b0, 1'b1, 3'd0);
    issue_rand(op_move, src_a, tag_sgl, 1'b1, 1'b1, 3'd0);
    issue_rand(op_move, src_b, tag_dbl, 1'b0, 1'b0, 3'd0);
    for (int k = 0; k < 2; k++) begin
      issue_rand(op_recip_seed, src_a, tag_dbl, 1'b0, 1'b0, 3'd0);
      issue_rand(op_rsqrt_seed, src_a, tag_dbl, 1'b0, 1'b0, 3'd0);
      issue_rand(op_exp_norm, src_a, tag_dbl, 1'b0, 1'b0, 3'd0);
      issue_rand(op_recip_seed, src_a, tag_sgl, 1'b0, 1'b0, 3'd0);
      issue_rand(op_rsqrt_seed, src_a, tag_sgl, 1'b0, 1'b0, 3'd0);
      issue_rand(op_exp_norm, src_a, tag_sgl, 1'b0, 1'b0, 3'd0);
    end
    // Zero exponent fields, and lanes with the leading one at each end.
    wz           = rand_word(tag_dbl);
    wz.dbl.exp_x = 1'b0;
    wz.dbl.exp   = '0;
    issue_op(op_exp_norm, src_a, 1'b0, 1'b0, 3'd0, '0, wz);
    wz              = rand_word(tag_sgl);
    wz.sgl.hi.exp_x = 1'b0;
    wz.sgl.hi.exp   = '0;
    wz.sgl.lo.exp_x = 1'b0;
    wz.sgl.lo.exp   = 8'h01;
    issue_op(op_exp_norm, src_a, 1'b0, 1'b0, 3'd0, '0, wz);
    wz.sgl.hi.exp_x = 1'b1;
    issue_op(op_exp_norm, src_a, 1'b0, 1'b0, 3'd0, '0, wz);
    // Table write and back-to-back read, then a write across a gap.
    issue_rand(op_tbl_write, src_a, tag_dbl, 1'b0, 1'b0, 3'd5);
    issue_rand(op_tbl_read, src_a, tag_dbl, 1'b0, 1'b0, 3'd5);
    issue_rand(op_tbl_write, src_a, tag_sgl, 1'b0, 1'b0, 3'd2);
    idle_cycles(3);
    issue_rand(op_tbl_read, src_a, tag_sgl, 1'b0, 1'b0, 3'd2);
    for (int i = 0; i < N_RAND; i++) begin
      issue_rand(perm_op_e'(3'($urandom_range(5, 0))), perm_src_e'($urandom_range(1, 0)),
                 fp_tag_e'(2'($urandom_range(1, 0))), 1'($urandom()), 1'($urandom()),
                 3'($urandom()));
    end
    idle_cycles(`FPERM_LAT + 2);  // Drain the pipeline.
    @(posedge clk);
    $display("issued %0d ops, assertion errors %0d, testbench errors %0d", n_issued,
             dut_i.props_i.err_cnt, tb_errs);
    if (dut_i.props_i.err_cnt == 0 && tb_errs == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // ------------------------------------------------------------------
  // Strobe check and timeout
  // ------------------------------------------------------------------

  always @(posedge clk) begin
    if (rst) begin
      pend0 <= 1'b0;
      pend1 <= 1'b0;
    end else begin
      pend0 <= issue && (op != op_tbl_write);  // Expected strobe two cycles on.
      pend1 <= pend0;
    end
  end

  always @(negedge clk) begin
    if (!rst && res_valid && !pend1) begin
      $display("error at %0t: res_valid = 1, expected 0 (no matching issue)", $time);
      tb_errs++;
    end
  end

  always @(posedge clk) begin
    cyc = cyc + 1;
    if (cyc > 8 + n_issued + 50) begin
      $display("timeout: run still going after %0d cycles", cyc);
      $display("Something failed");
      $finish;
    end
  end

endmodule

/* sim.f */
+incdir+src
src/fp_word_pkg.sv
src/fp_op_pkg.sv
src/fp_lead_one.sv
src/fp_exp_seed.sv
src/fp_seed_table.sv
src/fperm.sv
src/fperm_top.sv
sim/fperm_props.sv
sim/tb_clock.sv
sim/fperm_tb.sv

/* Bender.yml */
package:
  name: fperm

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/fp_word_pkg.sv
      - src/fp_op_pkg.sv
      - src/fp_lead_one.sv
      - src/fp_exp_seed.sv
      - src/fp_seed_table.sv
      - src/fperm.sv
      - src/fperm_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - sim/fperm_props.sv
      - sim/tb_clock.sv
      - sim/fperm_tb.sv
